/* common/eeprom_pkg.sv */
`default_nettype none

package eeprom_pkg;

    // 24C16 organisation, 8 blocks of 256 bytes
    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;
    localparam int BLOCK_W = 3;

    // fixed upper nibble of the control byte
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    // last bit of the control byte
    localparam logic RW_WRITE = 1'b0;
    localparam logic RW_READ = 1'b1;

    typedef logic [ADDR_W-1:0] eeprom_addr_t;
    typedef logic [DATA_W-1:0] eeprom_data_t;

    // upper address bits, sent inside the control byte
    typedef logic [BLOCK_W-1:0] eeprom_block_t;

    typedef struct packed {
        logic         write;    // 0 = random read
        eeprom_addr_t addr;
        eeprom_data_t data;     // write data only
    } eeprom_req_t;

    typedef struct packed {
        eeprom_data_t data;     // 0 unless a read completed
        logic         nack;
    } eeprom_rsp_t;

endpackage

`default_nettype wire

/* common/serial_pkg.sv */
`default_nettype none

package serial_pkg;

    // bit timing, in CLK cycles
    localparam int PHASES_PER_BIT = 4;
    localparam int BITS_PER_BYTE_ACK = 9;

    localparam int PHASE_W = $clog2(PHASES_PER_BIT);
    localparam int BIT_W = $clog2(BITS_PER_BYTE_ACK);

    typedef logic [PHASE_W-1:0] phase_t;
    typedef logic [BIT_W-1:0] bit_idx_t;
    typedef logic [7:0] ser_byte_t;

    localparam phase_t PHASE_SET = phase_t'(0);      // scl low, sda updated
    localparam phase_t PHASE_RISE = phase_t'(1);
    localparam phase_t PHASE_SAMPLE = phase_t'(2);
    localparam phase_t PHASE_FALL = phase_t'(PHASES_PER_BIT - 1);
    localparam bit_idx_t LAST_BIT = bit_idx_t'(BITS_PER_BYTE_ACK - 1);  // ack slot

    typedef enum logic [2:0] {
        STEP_START,
        STEP_STOP,
        STEP_SEND,
        STEP_RECV
    } bus_step_e;

    typedef struct packed {
        bus_step_e step;
        ser_byte_t tx_byte;
        logic      ack_out;     // recv only, driven in the ack slot
    } step_cmd_t;

    typedef struct packed {
        ser_byte_t rx_byte;
        logic      ack_in;      // 0 = slave acknowledged
    } step_res_t;

endpackage

`default_nettype wire

/* eeprom_access.f */
common/eeprom_pkg.sv
common/serial_pkg.sv
serial/serial_phy.sv
verilog/access_sequencer.sv
verilog/eeprom_access.sv
tests/eeprom_model.sv
tests/eeprom_access_assertions.sv
tests/tb_eeprom_access.sv

/* run_sim.sh */
#!/bin/sh
# build and run the eeprom_access testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module tb_eeprom_access \
    -f eeprom_access.f --Mdir obj_dir -o sim_eeprom_access
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_eeprom_access)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "test passed"; then
    exit 0
fi
exit 1

/* serial/serial_phy.sv */
`timescale 1ns/1ps
`default_nettype none

module serial_phy (
    input  wire                   CLK,
    input  wire                   RESET,
    input  wire                   step_valid,
    input  wire serial_pkg::step_cmd_t step_cmd,
    output logic                  step_done,
    output serial_pkg::step_res_t step_res,
    output logic                  scl,
    output logic                  sda_out,
    output logic                  sda_oe,
    input  wire                   sda_in
);

    typedef enum logic [1:0] {
        IDLE,
        START,
        STOP,
        BITS
    } phy_state_e;

    phy_state_e state;
    serial_pkg::phase_t phase;
    serial_pkg::bit_idx_t bit_cnt;
    serial_pkg::ser_byte_t tx_shift;
    serial_pkg::ser_byte_t rx_shift;
    logic recv;
    logic ack_out_q;
    logic ack_in_q;

    // bus levels held between steps
    logic scl_hold;
    logic sda_out_hold;
    logic sda_oe_hold;

    logic [2:0] edge_idx;   // position inside start/stop
    logic last_phase;
    logic step_end;

    assign edge_idx = {bit_cnt[0], phase};
    assign last_phase = (phase == serial_pkg::PHASE_FALL);

    always_comb
    begin
        step_end = 1'b0;
        case (state)
            START, STOP: step_end = (edge_idx == 3'd7);
            BITS:        step_end = last_phase && (bit_cnt == serial_pkg::LAST_BIT);
            default:     step_end = 1'b0;
        endcase
    end

    assign step_done = step_end;
    assign step_res = {rx_shift, ack_in_q};

    always_comb
    begin
        scl = scl_hold;
        sda_out = sda_out_hold;
        sda_oe = sda_oe_hold;
        case (state)
            START:
            begin
                // sda falls in the middle of the scl high time
                scl = (edge_idx >= 3'd2) && (edge_idx <= 3'd6);
                sda_oe = (edge_idx >= 3'd5);
                sda_out = !sda_oe;
            end
            STOP:
            begin
                scl = (edge_idx >= 3'd2);
                sda_oe = (edge_idx < 3'd5);     // release with scl high
                sda_out = !sda_oe;
            end
            BITS:
            begin
                scl = (phase == serial_pkg::PHASE_RISE) || (phase == serial_pkg::PHASE_SAMPLE);
                if (bit_cnt == serial_pkg::LAST_BIT)
                begin
                    sda_oe = recv;          // master acks only on receive
                    sda_out = recv ? ack_out_q : 1'b1;
                end
                else
                begin
                    sda_oe = !recv;
                    sda_out = recv ? 1'b1 : tx_shift[7];   // msb first
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= IDLE;
            phase <= serial_pkg::PHASE_SET;
            bit_cnt <= '0;
            scl_hold <= 1'b1;       // bus idle
            sda_out_hold <= 1'b1;
            sda_oe_hold <= 1'b0;
        end
        else
        begin
            scl_hold <= scl;
            sda_out_hold <= sda_out;
            sda_oe_hold <= sda_oe;
            if (state == IDLE)
            begin
                phase <= serial_pkg::PHASE_SET;
                bit_cnt <= '0;
                if (step_valid)
                begin
                    case (step_cmd.step)
                        serial_pkg::STEP_START: state <= START;
                        serial_pkg::STEP_STOP:  state <= STOP;
                        serial_pkg::STEP_SEND,
                        serial_pkg::STEP_RECV:  state <= BITS;
                        default:                state <= IDLE;
                    endcase
                end
            end
            else
            begin
                phase <= phase + 1'b1;
                if (last_phase)
                    bit_cnt <= bit_cnt + 1'b1;
                if (step_end)
                    state <= IDLE;
            end
        end
    end

    // step capture and byte shifting
    always_ff @(posedge CLK)
    begin
        if (state == IDLE && step_valid)
        begin
            tx_shift <= step_cmd.tx_byte;
            recv <= (step_cmd.step == serial_pkg::STEP_RECV);
            ack_out_q <= step_cmd.ack_out;
        end
        else if (state == BITS)
        begin
            if (phase == serial_pkg::PHASE_SAMPLE)
            begin
                if (bit_cnt == serial_pkg::LAST_BIT)
                    ack_in_q <= sda_in;
                else
                    rx_shift <= {rx_shift[6:0], sda_in};
            end
            if (last_phase)
                tx_shift <= {tx_shift[6:0], 1'b0};   // next bit to msb
        end
    end

endmodule

`default_nettype wire

/* tests/eeprom_access_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_access_assertions (
    input wire       CLK,
    input wire       RESET,
    input wire [1:0] phy_state,
    input wire       scl,
    input wire       sda_out,
    input wire       sda_oe,
    input wire       step_done
);

    // serial_phy state encoding
    localparam logic [1:0] PHY_START = 2'd1;
    localparam logic [1:0] PHY_STOP = 2'd2;

    logic drive_low;
    logic edge_step;

    assign drive_low = sda_oe && !sda_out;
    assign edge_step = (phy_state == PHY_START) || (phy_state == PHY_STOP);

    // data only moves while scl is low
    sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && (drive_low != $past(drive_low))) |-> edge_step)
        else $error("sda changed with scl high outside start or stop");

    done_pulse: assert property (@(posedge CLK) disable iff (RESET)
        step_done |=> !step_done)
        else $error("step_done longer than one cycle");

    reset_idle: assert property (@(posedge CLK) RESET |=> (!sda_oe && scl))
        else $error("bus not idle after reset");

endmodule

`default_nettype wire

/* tests/eeprom_model.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_model (
    input  wire  scl,
    input  wire  sda,
    input  wire  absent,    // ignore the bus entirely
    output logic sda_pull   // 1 pulls sda low
);

    typedef enum logic [2:0] {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_WDATA,
        M_RDATA
    } model_mode_e;

    eeprom_pkg::eeprom_data_t mem [0:2047];
    model_mode_e mode;
    model_mode_e next_mode;
    eeprom_pkg::eeprom_addr_t ptr;
    logic [7:0] shift;
    logic [7:0] rd_byte;
    int nbit;               // scl rising edges in the current byte
    logic scl_prev;
    logic sda_prev;

    // falling scl after the eighth bit, decide on the ack
    task automatic take_byte();
        next_mode = M_IDLE;
        case (mode)
            M_CTRL:
            begin
                if (shift[7:4] == eeprom_pkg::DEVICE_CODE)
                begin
                    sda_pull = 1'b1;
                    ptr[10:8] = shift[3:1];     // block bits
                    next_mode = shift[0] ? M_RDATA : M_ADDR;
                    rd_byte = mem[ptr];
                end
            end
            M_ADDR:
            begin
                sda_pull = 1'b1;
                ptr[7:0] = shift;
                next_mode = M_WDATA;
            end
            M_WDATA:
            begin
                sda_pull = 1'b1;
                mem[ptr] = shift;
            end
            default: sda_pull = 1'b0;   // master answers the read byte
        endcase
    endtask

    task automatic track_bus(input logic scl_now, input logic sda_now);
        if (absent === 1'b1)
        begin
            mode = M_IDLE;
            sda_pull = 1'b0;
        end
        else if (scl_now && scl_prev && (sda_prev != sda_now))
        begin
            // falling sda is a start, rising sda a stop
            mode = sda_now ? M_IDLE : M_CTRL;
            nbit = 0;
            sda_pull = 1'b0;
        end
        else if (scl_now && !scl_prev && mode != M_IDLE)
        begin
            if (mode != M_RDATA && nbit < 8)
                shift = {shift[6:0], sda_now};
            nbit++;
        end
        else if (!scl_now && scl_prev && mode != M_IDLE)
        begin
            if (nbit == 8)
                take_byte();
            else if (nbit == 9)
            begin
                nbit = 0;
                mode = next_mode;
                sda_pull = 1'b0;    // ack slot over
            end
            if (mode == M_RDATA && nbit < 8)
            begin
                sda_pull = !rd_byte[7];
                rd_byte = {rd_byte[6:0], 1'b0};
            end
        end
        scl_prev = scl_now;
        sda_prev = sda_now;
    endtask

    initial
    begin
        eeprom_pkg::eeprom_addr_t a;
        a = '0;
        do
        begin
            mem[a] = 8'hff;     // erased
            a = a + 1'b1;
        end
        while (a != '0);
        mode = M_IDLE;
        next_mode = M_IDLE;
        ptr = '0;
        shift = '0;
        rd_byte = '0;
        nbit = 0;
        sda_pull = 1'b0;
        scl_prev = 1'b1;
        sda_prev = 1'b1;
        forever
        begin
            @(scl or sda or absent);
            track_bus(scl === 1'b1, sda !== 1'b0);
        end
    end

endmodule

`default_nettype wire

/* tests/eeprom_vectors.txt */
# op addr data absent exp_data exp_nack, all hex
# op 0 read, 1 write, 2 write with a second request given while busy
1 123 5a 0 00 0
0 123 00 0 5a 0
0 045 00 0 ff 0
1 010 11 0 00 0
1 110 22 0 00 0
1 710 77 0 00 0
0 010 00 0 11 0
0 110 00 0 22 0
0 710 00 0 77 0
1 123 a5 1 00 1
0 123 00 1 00 1
0 123 00 0 5a 0
2 3ff c3 0 00 0
0 3ff 00 0 c3 0
0 7ff 00 0 ff 0
1 000 00 0 00 0
0 000 00 0 00 0

/* tests/tb_eeprom_access.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_access;

    localparam int WAIT_LIMIT = 400;
    localparam int QUIET_CYCLES = 150;  // longer than a whole write

    logic CLK = 1'b0;
    logic RESET;
    logic req_valid;
    eeprom_pkg::eeprom_req_t req;
    logic busy;
    logic rsp_valid;
    eeprom_pkg::eeprom_rsp_t rsp;
    logic scl;
    logic sda_out;
    logic sda_oe;
    wire sda_line;
    logic model_pull;
    logic model_absent;
    int mismatches;
    int timeouts;
    int other_errors;
    bit timed_out;

    assign sda_line = !((sda_oe && !sda_out) || model_pull);   // open drain, pulled up

    eeprom_access i_dut (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .scl       (scl),
        .sda_out   (sda_out),
        .sda_oe    (sda_oe),
        .sda_in    (sda_line)
    );

    eeprom_model i_model (
        .scl      (scl),
        .sda      (sda_line),
        .absent   (model_absent),
        .sda_pull (model_pull)
    );

    bind serial_phy eeprom_access_assertions i_phy_assert (
        .CLK       (CLK),
        .RESET     (RESET),
        .phy_state (state),
        .scl       (scl),
        .sda_out   (sda_out),
        .sda_oe    (sda_oe),
        .step_done (step_done)
    );

    always #20 CLK = ~CLK;

    task automatic check_rsp(input eeprom_pkg::eeprom_rsp_t got,
                             input eeprom_pkg::eeprom_rsp_t exp);
        if (got !== exp)
        begin
            mismatches++;
            $display("FAIL %0t rsp got data %h nack %b expected data %h nack %b",
                     $time, got.data, got.nack, exp.data, exp.nack);
        end
    endtask

    task automatic check_busy(input logic got, input logic exp);
        if (got !== exp)
        begin
            mismatches++;
            $display("FAIL %0t busy got %b expected %b", $time, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            mismatches++;
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_idle();
        check_busy(busy, 1'b0);
        check_flag("rsp_valid", rsp_valid, 1'b0);
        check_flag("scl", scl, 1'b1);
        check_flag("sda_oe", sda_oe, 1'b0);
    endtask

    // one-cycle strobe, accepted on the second edge
    task automatic drive_req(input eeprom_pkg::eeprom_req_t r);
        @(posedge CLK);
        #2;
        req_valid = 1'b1;
        req = r;
        @(posedge CLK);
        #2;
        req_valid = 1'b0;
        req = '0;
    endtask

    task automatic wait_busy(input logic level);
        int n;
        n = 0;
        @(negedge CLK);
        while (busy !== level && n < WAIT_LIMIT)
        begin
            @(negedge CLK);
            n++;
        end
        if (busy !== level)
        begin
            timeouts++;
            timed_out = 1'b1;
            $display("busy did not reach %b within %0d cycles at %0t", level, WAIT_LIMIT, $time);
        end
    endtask

    task automatic wait_rsp(output eeprom_pkg::eeprom_rsp_t got);
        int n;
        n = 0;
        got = '0;
        @(negedge CLK);
        while (rsp_valid !== 1'b1 && n < WAIT_LIMIT)
        begin
            @(negedge CLK);
            n++;
        end
        if (rsp_valid === 1'b1)
            got = rsp;
        else
        begin
            timeouts++;
            timed_out = 1'b1;
            $display("no response within %0d cycles at %0t", WAIT_LIMIT, $time);
        end
    endtask

    // op 0 read, 1 write, 2 write with a second request while busy
    task automatic run_op(input logic [3:0] op, input eeprom_pkg::eeprom_addr_t addr,
                          input eeprom_pkg::eeprom_data_t data, input logic absent,
                          input eeprom_pkg::eeprom_data_t exp_data, input logic exp_nack);
        eeprom_pkg::eeprom_req_t r;
        eeprom_pkg::eeprom_req_t extra;
        eeprom_pkg::eeprom_rsp_t got;
        eeprom_pkg::eeprom_rsp_t exp;
        r.write = (op != 4'd0);
        r.addr = addr;
        r.data = data;
        extra = r;
        extra.data = ~data;
        exp.data = exp_data;
        exp.nack = exp_nack;
        model_absent = absent;
        drive_req(r);
        if (op == 4'd2)
        begin
            wait_busy(1'b1);
            if (!timed_out)
                drive_req(extra);   // must be dropped
        end
        if (!timed_out)
            wait_rsp(got);
        if (!timed_out)
        begin
            check_rsp(got, exp);
            check_busy(busy, 1'b0);
        end
        if (!timed_out && op == 4'd2)
        begin
            repeat (QUIET_CYCLES)
            begin
                @(negedge CLK);
                check_flag("rsp_valid", rsp_valid, 1'b0);
                check_busy(busy, 1'b0);
            end
        end
        if (!timed_out)
        begin
            @(negedge CLK);
            check_idle();
        end
    endtask

    initial
    begin
        int fd;
        int ops;
        string line;
        logic [3:0] op;
        eeprom_pkg::eeprom_addr_t addr;
        eeprom_pkg::eeprom_data_t data;
        logic absent;
        eeprom_pkg::eeprom_data_t exp_data;
        logic exp_nack;
        RESET = 1'b1;
        req_valid = 1'b0;
        req = '0;
        model_absent = 1'b0;
        mismatches = 0;
        timeouts = 0;
        other_errors = 0;
        timed_out = 1'b0;
        ops = 0;
        repeat (2) @(posedge CLK);
        #2;
        RESET = 1'b0;
        @(negedge CLK);
        check_idle();
        fd = $fopen("tests/eeprom_vectors.txt", "r");
        if (fd == 0)
        begin
            other_errors++;
            $display("could not open tests/eeprom_vectors.txt");
        end
        else
        begin
            while (!timed_out && !$feof(fd))
            begin
                line = "";
                if ($fgets(line, fd) > 0)
                begin
                    // comment and blank lines do not scan
                    if ($sscanf(line, "%h %h %h %h %h %h", op, addr, data, absent,
                                exp_data, exp_nack) == 6)
                    begin
                        run_op(op, addr, data, absent, exp_data, exp_nack);
                        ops++;
                    end
                end
            end
            $fclose(fd);
            if (ops == 0)
            begin
                other_errors++;
                $display("vector file held no operations");
            end
        end
        $display("errors: %0d mismatches, %0d timeouts, %0d other", mismatches, timeouts,
                 other_errors);
        if (mismatches == 0 && timeouts == 0 && other_errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/access_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module access_sequencer (
    input  wire                     CLK,
    input  wire                     RESET,
    input  wire                     req_valid,
    input  wire eeprom_pkg::eeprom_req_t req,
    output logic                    busy,
    output logic                    rsp_valid,
    output eeprom_pkg::eeprom_rsp_t rsp,
    output logic                    step_valid,
    output serial_pkg::step_cmd_t   step_cmd,
    input  wire                     step_done,
    input  wire serial_pkg::step_res_t step_res
);

    typedef enum logic [3:0] {
        IDLE,
        START,
        CTRL_WR,
        ADDR,
        DATA_WR,
        RESTART,
        CTRL_RD,
        DATA_RD,
        STOP,
        RESPOND
    } seq_state_e;

    seq_state_e state;
    seq_state_e next_state;
    eeprom_pkg::eeprom_req_t req_q;
    eeprom_pkg::eeprom_block_t block;
    eeprom_pkg::eeprom_data_t rd_data;
    logic nack;
    logic accept;
    logic refused;

    // busy drops in RESPOND so the host can queue the next request
    assign busy = (state != IDLE) && (state != RESPOND);
    assign accept = req_valid && !busy;
    assign rsp_valid = (state == RESPOND);
    assign rsp = {rd_data, nack};

    assign block = req_q.addr[10:8];
    assign refused = (step_cmd.step == serial_pkg::STEP_SEND) && step_res.ack_in;

    always_comb
    begin
        step_cmd.step = serial_pkg::STEP_STOP;
        step_cmd.tx_byte = '0;
        step_cmd.ack_out = 1'b0;
        case (state)
            START, RESTART:
                step_cmd.step = serial_pkg::STEP_START;
            CTRL_WR:
            begin
                step_cmd.step = serial_pkg::STEP_SEND;
                step_cmd.tx_byte = {eeprom_pkg::DEVICE_CODE, block, eeprom_pkg::RW_WRITE};
            end
            ADDR:
            begin
                step_cmd.step = serial_pkg::STEP_SEND;
                step_cmd.tx_byte = req_q.addr[7:0];
            end
            DATA_WR:
            begin
                step_cmd.step = serial_pkg::STEP_SEND;
                step_cmd.tx_byte = req_q.data;
            end
            CTRL_RD:
            begin
                step_cmd.step = serial_pkg::STEP_SEND;
                step_cmd.tx_byte = {eeprom_pkg::DEVICE_CODE, block, eeprom_pkg::RW_READ};
            end
            DATA_RD:
            begin
                step_cmd.step = serial_pkg::STEP_RECV;
                step_cmd.ack_out = 1'b1;    // single byte, end with no-ack
            end
            default: ;
        endcase
    end

    always_comb
    begin
        case (state)
            START:   next_state = CTRL_WR;
            CTRL_WR: next_state = refused ? STOP : ADDR;
            ADDR:
            begin
                if (refused)
                    next_state = STOP;
                else
                    next_state = req_q.write ? DATA_WR : RESTART;
            end
            DATA_WR: next_state = STOP;
            RESTART: next_state = CTRL_RD;
            CTRL_RD: next_state = refused ? STOP : DATA_RD;
            DATA_RD: next_state = STOP;
            STOP:    next_state = RESPOND;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state <= IDLE;
            step_valid <= 1'b0;
            nack <= 1'b0;
            rd_data <= '0;
        end
        else
        begin
            step_valid <= 1'b0;
            if (state == IDLE || state == RESPOND)
            begin
                state <= IDLE;
                if (accept)
                begin
                    state <= START;
                    step_valid <= 1'b1;
                    nack <= 1'b0;
                    rd_data <= '0;
                end
            end
            else if (step_done)
            begin
                state <= next_state;
                step_valid <= (next_state != RESPOND);
                if (refused)
                    nack <= 1'b1;
                if (state == DATA_RD)
                    rd_data <= step_res.rx_byte;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
            req_q <= req;
    end

endmodule

`default_nettype wire

/* verilog/eeprom_access.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_access (
    input  wire                     CLK,
    input  wire                     RESET,
    input  wire                     req_valid,
    input  wire eeprom_pkg::eeprom_req_t req,
    output logic                    busy,
    output logic                    rsp_valid,
    output eeprom_pkg::eeprom_rsp_t rsp,
    output logic                    scl,
    output logic                    sda_out,
    output logic                    sda_oe,
    input  wire                     sda_in
);

    logic step_valid;
    logic step_done;
    serial_pkg::step_cmd_t step_cmd;
    serial_pkg::step_res_t step_res;

    access_sequencer i_seq (
        .CLK        (CLK),
        .RESET      (RESET),
        .req_valid  (req_valid),
        .req        (req),
        .busy       (busy),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .step_valid (step_valid),
        .step_cmd   (step_cmd),
        .step_done  (step_done),
        .step_res   (step_res)
    );

    // bus engine, sda resolved outside
    serial_phy i_phy (
        .CLK        (CLK),
        .RESET      (RESET),
        .step_valid (step_valid),
        .step_cmd   (step_cmd),
        .step_done  (step_done),
        .step_res   (step_res),
        .scl        (scl),
        .sda_out    (sda_out),
        .sda_oe     (sda_oe),
        .sda_in     (sda_in)
    );

endmodule

`default_nettype wire
